/* verilog/serdes_cfg_pkg.sv */
package serdes_cfg_pkg;

	// ----------------------------------------------------------
	// serializer side
	// ----------------------------------------------------------
	localparam int unsigned BIT_DEPTH = 8; // bit clocks per serialized word
	localparam int unsigned LANE_COUNT = 4; // serializer lanes fed by one strobe

	// ----------------------------------------------------------
	// deserializer side
	// ----------------------------------------------------------
	localparam int unsigned DESER_DEPTH = 4; // bits collected per output word

	// ----------------------------------------------------------
	// strobe generator
	// ----------------------------------------------------------
	// stands in for the pll and bufpll lock time, counted in bit clocks
	localparam int unsigned LOCK_CYCLES_DEFAULT = 16; // settle time before locked rises

endpackage

/* verilog/serdes_types_pkg.sv */
package serdes_types_pkg;

	import serdes_cfg_pkg::*;

	// ----------------------------------------------------------
	// data words
	// ----------------------------------------------------------
	typedef logic [BIT_DEPTH-1:0] ser_word_t; // one lane's parallel word
	typedef logic [DESER_DEPTH-1:0] deser_word_t; // one collected word

	// ----------------------------------------------------------
	// framing counters
	// ----------------------------------------------------------
	typedef logic [$clog2(BIT_DEPTH)-1:0] bit_count_t; // position in serializer word
	typedef logic [$clog2(DESER_DEPTH)-1:0] deser_count_t; // position in deser word

	// ----------------------------------------------------------
	// lane bundles
	// ----------------------------------------------------------
	typedef struct packed {
		ser_word_t lane0; // most significant slice of the bundle
		ser_word_t lane1;
		ser_word_t lane2;
		ser_word_t lane3; // least significant slice
	} quad_word_t;

	typedef struct packed {
		logic d0; // serial out of lane0
		logic d1;
		logic d2;
		logic d3; // serial out of lane3
	} quad_serial_t;

	typedef enum logic {
		SETTLING, // counting settle cycles, outputs quiet
		RUNNING // locked, bit counter free-runs
	} strobe_state_t;

endpackage

/* verilog/word_strobe_gen.sv */
`timescale 1ns/1ps

module word_strobe_gen
	import serdes_cfg_pkg::*;
	import serdes_types_pkg::*;
#(
	parameter int unsigned LOCK_CYCLES = LOCK_CYCLES_DEFAULT // bit clocks until locked
) (
	input logic clock,
	input logic rst_n,
	output logic word_strobe,
	output logic locked
);

	localparam int unsigned SETTLE_W = $clog2(LOCK_CYCLES + 1); // holds 0..LOCK_CYCLES
	localparam bit_count_t LAST_BIT = bit_count_t'(BIT_DEPTH - 1); // strobe position

	strobe_state_t state; // settling until the settle count runs out
	logic [SETTLE_W-1:0] settle_cnt; // edges seen since reset release
	bit_count_t bit_cnt; // divides the bit clock down to the word rate

	// ----------------------------------------------------------
	// lock settle fsm and bit counter
	// ----------------------------------------------------------
	always_ff @(posedge clock) begin
		if (!rst_n) begin
			state <= SETTLING;
			settle_cnt <= '0;
			bit_cnt <= '0; // first locked cycle sits at position 0
		end else begin
			case (state)
				SETTLING: begin
					settle_cnt <= settle_cnt + 1'b1;
					// LOCK_CYCLES-th edge after release
					if (settle_cnt == SETTLE_W'(LOCK_CYCLES - 1)) begin
						state <= RUNNING;
					end
				end
				RUNNING: begin
					if (bit_cnt == LAST_BIT) begin
						bit_cnt <= '0; // wrap at word boundary
					end else begin
						bit_cnt <= bit_cnt + 1'b1;
					end
				end
			endcase
		end
	end

	// ----------------------------------------------------------
	// outputs decoded from registers
	// ----------------------------------------------------------
	assign locked = (state == RUNNING); // stays high until the next reset
	// one pulse per word with the first BIT_DEPTH-1 cycles after lock
	assign word_strobe = locked && (bit_cnt == LAST_BIT);

endmodule

/* verilog/lane_serializer.sv */
`timescale 1ns/1ps

module lane_serializer
	import serdes_cfg_pkg::*;
	import serdes_types_pkg::*;
(
	input logic clock,
	input logic rst_n,
	input logic word_strobe, // load pulse shared by all lanes
	input ser_word_t word, // must be stable on the strobe edge
	output logic d // serial out with msb first
);

	ser_word_t shift_reg; // loaded word on its way out

	// ----------------------------------------------------------
	// load and shift
	// ----------------------------------------------------------
	// a load on the strobe edge shows word[msb] on d the next cycle,
	// then one lower bit per cycle; zeros fill in from the bottom
	always_ff @(posedge clock) begin
		if (!rst_n) begin
			shift_reg <= '0; // keeps d low through reset and settling
		end else if (word_strobe) begin
			shift_reg <= word; // next word starts right as the last bit leaves
		end else begin
			shift_reg <= {shift_reg[BIT_DEPTH-2:0], 1'b0}; // move toward msb
		end
	end

	assign d = shift_reg[BIT_DEPTH-1]; // msb is the line bit

endmodule

/* verilog/word_deserializer.sv */
`timescale 1ns/1ps

module word_deserializer
	import serdes_cfg_pkg::*;
	import serdes_types_pkg::*;
(
	input logic clock,
	input logic rst_n,
	input logic data_in, // serial in with the first bit of a frame as msb
	output deser_word_t word_out, // last completed frame
	output logic word_valid // one cycle per completed frame
);

	localparam deser_count_t LAST_SAMPLE = deser_count_t'(DESER_DEPTH - 1);

	deser_count_t frame_cnt; // own framing independent of locked
	deser_word_t shift_reg; // partial frame with the oldest bit on top
	deser_word_t next_word; // frame as it stands after this sample

	assign next_word = {shift_reg[DESER_DEPTH-2:0], data_in};

	// ----------------------------------------------------------
	// sample shifter
	// ----------------------------------------------------------
	// the DESER_DEPTH samples of a frame flush the whole register
	always_ff @(posedge clock) begin
		shift_reg <= next_word; // sample on every edge
	end

	// ----------------------------------------------------------
	// framing and word register
	// ----------------------------------------------------------
	always_ff @(posedge clock) begin
		if (!rst_n) begin
			frame_cnt <= '0; // frame starts at the first edge after reset
			word_out <= '0;
			word_valid <= 1'b0;
		end else begin
			word_valid <= 1'b0; // pulse only
			if (frame_cnt == LAST_SAMPLE) begin
				frame_cnt <= '0;
				word_out <= next_word; // held until the next frame completes
				word_valid <= 1'b1;
			end else begin
				frame_cnt <= frame_cnt + 1'b1;
			end
		end
	end

endmodule

/* verilog/ocyrus_quad_top.sv */
`timescale 1ns/1ps

module ocyrus_quad_top
	import serdes_cfg_pkg::*;
	import serdes_types_pkg::*;
#(
	parameter int unsigned LOCK_CYCLES = LOCK_CYCLES_DEFAULT // settle time in bit clocks
) (
	input logic clock, // bit clock, the only clock
	input logic rst_n,
	input quad_word_t word_in, // one word per lane, taken on word_strobe
	input logic data_in, // deserializer serial in
	output quad_serial_t d_out, // one serial bit per lane
	output logic word_strobe,
	output logic locked,
	output deser_word_t word_out,
	output logic word_valid
);

	logic [LANE_COUNT-1:0] lane_d; // serial outs, indexed by lane

	// ----------------------------------------------------------
	// word strobe and lock
	// ----------------------------------------------------------
	word_strobe_gen #(
		.LOCK_CYCLES(LOCK_CYCLES)
	) word_strobe_gen_inst (
		.clock(clock),
		.rst_n(rst_n),
		.word_strobe(word_strobe), // fans out to every lane
		.locked(locked)
	);

	// ----------------------------------------------------------
	// serializer lanes, peers on one strobe
	// ----------------------------------------------------------
	lane_serializer lane0 (
		.clock(clock), .rst_n(rst_n), .word_strobe(word_strobe),
		.word(word_in.lane0), .d(lane_d[0])
	);
	lane_serializer lane1 (
		.clock(clock), .rst_n(rst_n), .word_strobe(word_strobe),
		.word(word_in.lane1), .d(lane_d[1])
	);
	lane_serializer lane2 (
		.clock(clock), .rst_n(rst_n), .word_strobe(word_strobe),
		.word(word_in.lane2), .d(lane_d[2])
	);
	lane_serializer lane3 (
		.clock(clock), .rst_n(rst_n), .word_strobe(word_strobe),
		.word(word_in.lane3), .d(lane_d[3])
	);

	// lane n lands on field dn of the output bundle
	assign d_out = '{d0: lane_d[0], d1: lane_d[1], d2: lane_d[2], d3: lane_d[3]};

	// ----------------------------------------------------------
	// single-lane deserializer
	// ----------------------------------------------------------
	word_deserializer word_deserializer_inst (
		.clock(clock),
		.rst_n(rst_n),
		.data_in(data_in),
		.word_out(word_out),
		.word_valid(word_valid) // framed from reset, not from locked
	);

endmodule

/* tb/ocyrus_quad_tb.sv */
`timescale 1ns/1ps

module ocyrus_quad_tb
	import serdes_cfg_pkg::*;
	import serdes_types_pkg::*;
();

	localparam int LOCK = 16; // settle time given to the dut
	localparam int BD = int'(BIT_DEPTH);
	localparam int DD = int'(DESER_DEPTH);
	localparam int RESET_CYCLES = 10;
	localparam int COLS = 5; // four lane words and one nibble per line
	localparam int STIM_FRAMES = 36; // data lines in the stimulus file
	localparam int RANDOM_FRAMES = 20;
	localparam int RERUN_FRAMES = 4; // frames after the mid-run reset
	localparam int TOTAL_FRAMES = STIM_FRAMES + RANDOM_FRAMES + RERUN_FRAMES;
	localparam int WATCHDOG_NS = (TOTAL_FRAMES + 4) * BD * 8 * 2;

	logic clock;
	logic rst_n;
	quad_word_t word_in;
	logic data_in;
	quad_serial_t d_out;
	logic word_strobe;
	logic locked;
	deser_word_t word_out;
	logic word_valid;

	logic [8:0] stim_mem [STIM_FRAMES*COLS]; // bit 8 marks an entry the file never wrote
	int seed; // $random state
	int ser_idx; // next lane frame to hand out
	int deser_idx; // next nibble to hand out
	quad_word_t lane_q[$]; // words driven and waiting for their load edge
	deser_word_t nib_q[$]; // nibbles driven and waiting for word_valid
	quad_word_t cur_words; // words now leaving the lanes
	int bit_pos; // bits shown since the load or -1 before the first load
	deser_word_t cur_nib; // nibble now on data_in
	deser_word_t exp_word; // word_out as the model sees it

	ocyrus_quad_top #(
		.LOCK_CYCLES(LOCK)
	) ocyrus_quad_top_inst (
		.clock(clock),
		.rst_n(rst_n),
		.word_in(word_in),
		.data_in(data_in),
		.d_out(d_out),
		.word_strobe(word_strobe),
		.locked(locked),
		.word_out(word_out),
		.word_valid(word_valid)
	);

	always #4 clock = ~clock; // 8 ns bit clock

	// ----------------------------------------------------------
	// watchdog
	// ----------------------------------------------------------
	initial begin
		#(WATCHDOG_NS);
		$display("Timeout: the run did not finish within %0d ns", WATCHDOG_NS);
		$display("Test FAILED");
		$fatal(1, "watchdog expired");
	end

	// ----------------------------------------------------------
	// checks and reference model
	// ----------------------------------------------------------
	task automatic check_value(input string what, input logic [31:0] got,
			input logic [31:0] exp);
		if (got !== exp) begin
			$display("Fail at %0d ns: %s is %0h, expected %0h", $time, what, got, exp);
			$display("Test FAILED");
			$fatal(1, "output mismatch");
		end
	endtask

	function automatic logic strobe_at(input int j);
		// strobe on the last counter position of each word once locked
		return (j >= LOCK) && ((j - LOCK) % BD == BD - 1);
	endfunction

	function automatic logic lane_bit(input ser_word_t w);
		if (bit_pos < 0 || bit_pos >= BD) begin
			return 1'b0; // nothing loaded yet
		end
		return w[BD - 1 - bit_pos]; // msb first
	endfunction

	task automatic check_quiet();
		check_value("locked", 32'(locked), 32'd0);
		check_value("word_strobe", 32'(word_strobe), 32'd0);
		check_value("word_valid", 32'(word_valid), 32'd0);
		check_value("d_out", 32'(d_out), 32'd0);
		check_value("word_out", 32'(word_out), 32'd0);
	endtask

	task automatic check_cycle(input int j);
		quad_serial_t exp_d;
		if (strobe_at(j - 1)) begin
			cur_words = lane_q.pop_front(); // load edge
			bit_pos = 0;
		end else if (bit_pos >= 0) begin
			bit_pos++;
		end
		exp_d = '{d0: lane_bit(cur_words.lane0), d1: lane_bit(cur_words.lane1),
			d2: lane_bit(cur_words.lane2), d3: lane_bit(cur_words.lane3)};
		if (j % DD == 0) begin
			exp_word = nib_q.pop_front(); // frame just completed
		end
		check_value("locked", 32'(locked), 32'(j >= LOCK));
		check_value("word_strobe", 32'(word_strobe), 32'(strobe_at(j)));
		check_value("d_out", 32'(d_out), 32'(exp_d));
		check_value("word_valid", 32'(word_valid), 32'(j % DD == 0));
		check_value("word_out", 32'(word_out), 32'(exp_word));
	endtask

	// ----------------------------------------------------------
	// stimulus
	// ----------------------------------------------------------
	task automatic load_stimulus();
		int i;
		for (i = 0; i < STIM_FRAMES * COLS; i++) begin
			stim_mem[i] = {1'b1, i[7:0]}; // marked as unwritten
		end
		$readmemh("tb/ocyrus_quad_stimulus.txt", stim_mem);
		for (i = 0; i < STIM_FRAMES * COLS; i++) begin
			if (stim_mem[i][8] || (i % COLS == COLS - 1 && stim_mem[i] > 9'h00f)) begin
				$display("Stimulus file is short or has a bad entry at position %0d", i);
				$display("Test FAILED");
				$fatal(1, "bad stimulus file");
			end
		end
	endtask

	function automatic quad_word_t next_frame();
		quad_word_t f;
		int base;
		base = ser_idx * COLS;
		if (ser_idx < STIM_FRAMES) begin
			f.lane0 = ser_word_t'(stim_mem[base]);
			f.lane1 = ser_word_t'(stim_mem[base + 1]);
			f.lane2 = ser_word_t'(stim_mem[base + 2]);
			f.lane3 = ser_word_t'(stim_mem[base + 3]);
		end else begin
			f.lane0 = ser_word_t'($random(seed)); // file used up
			f.lane1 = ser_word_t'($random(seed));
			f.lane2 = ser_word_t'($random(seed));
			f.lane3 = ser_word_t'($random(seed));
		end
		ser_idx++;
		return f;
	endfunction

	function automatic deser_word_t next_nibble();
		deser_word_t n;
		if (deser_idx < STIM_FRAMES) begin
			n = deser_word_t'(stim_mem[deser_idx * COLS + COLS - 1]);
		end else begin
			n = deser_word_t'($random(seed));
		end
		deser_idx++;
		return n;
	endfunction

	task automatic drive_lanes(input int j, input int frames);
		quad_word_t f;
		// new words half a word ahead of their load edge
		if (j >= LOCK + BD / 2 && (j - LOCK - BD / 2) % BD == 0
				&& (j - LOCK - BD / 2) / BD < frames) begin
			f = next_frame();
			word_in <= f;
			lane_q.push_back(f);
		end
	endtask

	task automatic drive_deser(input int m);
		if (m % DD == 0) begin
			cur_nib = next_nibble(); // sampled on edges m+1 to m+DD
			nib_q.push_back(cur_nib);
		end
		data_in <= cur_nib[DD - 1 - (m % DD)];
	endtask

	task automatic reset_phase();
		int i;
		@(posedge clock);
		rst_n <= 1'b0;
		for (i = 0; i < RESET_CYCLES; i++) begin
			@(posedge clock);
			if (i == RESET_CYCLES - 1) begin
				rst_n <= 1'b1; // release and drive the first deserializer bit
				drive_deser(0);
			end
			@(negedge clock);
			check_quiet();
		end
	endtask

	task automatic run_phase(input int frames, input int last_cycle);
		int j;
		lane_q.delete();
		nib_q.delete();
		bit_pos = -1;
		exp_word = '0;
		reset_phase();
		for (j = 1; j <= last_cycle; j++) begin
			@(posedge clock);
			drive_lanes(j, frames);
			drive_deser(j);
			@(negedge clock);
			check_cycle(j); // outputs after edge j
		end
	endtask

	// ----------------------------------------------------------
	// main sequence
	// ----------------------------------------------------------
	initial begin
		clock = 1'b0;
		rst_n = 1'b0;
		word_in = '0;
		data_in = 1'b0;
		seed = 87;
		ser_idx = 0;
		deser_idx = 0;
		cur_words = '0;
		cur_nib = '0;
		load_stimulus();
		// file frames then random ones up to the middle of the last word
		run_phase(STIM_FRAMES + RANDOM_FRAMES,
			LOCK + BD * (STIM_FRAMES + RANDOM_FRAMES) + BD / 2);
		// mid-run reset then the lock and strobe timing once more
		run_phase(RERUN_FRAMES, LOCK + BD * RERUN_FRAMES + BD - 1);
		$display("Test OK");
		$finish;
	end

endmodule

/* ocyrus_quad.f */
verilog/serdes_cfg_pkg.sv
verilog/serdes_types_pkg.sv
verilog/word_strobe_gen.sv
verilog/lane_serializer.sv
verilog/word_deserializer.sv
verilog/ocyrus_quad_top.sv
tb/ocyrus_quad_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build the quad serdes testbench with Verilator and run it.
# The exit status of the simulation is the verdict.
set -e

cd "$(dirname "$0")"

verilator --binary --timing -j 0 \
	--top-module ocyrus_quad_tb \
	-Mdir obj_dir \
	-f ocyrus_quad.f

# the stimulus path inside the testbench is relative to this directory
./obj_dir/Vocyrus_quad_tb

/* tb/ocyrus_quad_stimulus.txt */
// columns: lane0 lane1 lane2 lane3 deser, hex, one frame per line
// lane words go out msb first; deser is the 4-bit word driven on data_in
ff 00 ff 00 f
00 ff 00 ff 0
80 40 20 10 8
08 04 02 01 4
01 02 04 08 2
10 20 40 80 1
aa 55 aa 55 a
55 aa 55 aa 5
ff ff 00 00 c
00 00 ff ff 3
f0 0f f0 0f 9
0f f0 0f f0 6
12 34 56 78 7
9a bc de f0 e
c3 3c 81 7e b
7e 81 3c c3 d
ff 00 00 00 f
00 ff 00 00 0
00 00 ff 00 f
00 00 00 ff 0
00 ff ff ff 1
ff 00 ff ff 2
ff ff 00 ff 4
ff ff ff 00 8
de ad be ef 3
ca fe f0 0d 6
01 80 01 80 c
e7 18 e7 18 9
3a c5 5c a3 5
6b 94 d2 2d a
fe 7f ef f7 e
11 22 44 88 7
99 66 33 cc b
bd 42 db 24 d
00 00 00 00 0
ff ff ff ff f
